//--- verilog/irl_pkg.sv
//====================
// irl_pkg
// shared widths, payload types and apb register offsets
// for the ingress rate limiter
//====================

package irl_pkg;

	// flow number and packet length widths
	localparam int FLOW_NBITS = 2;
	localparam int NUM_FLOWS = 1 << FLOW_NBITS;
	localparam int LEN_NBITS = 14;

	// bucket level width
	localparam int TOKEN_NBITS = 20;

	// metadata from the classifier
	typedef struct packed {
		logic [FLOW_NBITS-1:0] flow;
		logic [LEN_NBITS-1:0] len;
	} irl_meta_t;

	// verdict towards downstream
	typedef struct packed {
		logic [FLOW_NBITS-1:0] flow;
		logic [LEN_NBITS-1:0] len;
		logic green;
	} irl_verdict_t;

	//====================
	// register map, byte offsets
	//====================
	localparam logic [7:0] REG_RATE_BASE = 8'h00;
	localparam logic [7:0] REG_CEIL = 8'h10;
	localparam logic [7:0] REG_OVFL = 8'h14;
	localparam logic [7:0] REG_RED_BASE = 8'h20;
	localparam logic [7:0] REG_TOKEN_BASE = 8'h40;

endpackage

//--- verilog/sfifo_ctrl.sv
//====================
// sfifo_ctrl
// pointer, occupancy and flag engine for a synchronous fifo
//====================

module sfifo_ctrl #(
	parameter int DEPTH_NBITS = 3
) (
	input logic clk,
	input logic rst_n,
	input logic rd,
	input logic wr,
	output logic [DEPTH_NBITS:0] count,
	output logic [DEPTH_NBITS:0] ncount,
	output logic full,
	output logic empty,
	output logic fullm1,
	output logic emptyp1,
	output logic [DEPTH_NBITS-1:0] rptr,
	output logic [DEPTH_NBITS-1:0] wptr
);

	localparam int DEPTH = 1 << DEPTH_NBITS;

	logic do_rd;
	logic do_wr;

	// drop write when full and read when empty
	assign do_rd = rd & ~empty;
	assign do_wr = wr & ~full;

	// next occupancy
	always_comb begin
		ncount = count;
		if (do_wr && !do_rd) begin
			ncount = count + 1'b1;
		end else if (do_rd && !do_wr) begin
			ncount = count - 1'b1;
		end
	end

	//====================
	// pointers
	//====================
	// pointers wrap on their own width
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rptr <= '0;
			wptr <= '0;
		end else begin
			if (do_rd) begin
				rptr <= rptr + 1'b1;
			end
			if (do_wr) begin
				wptr <= wptr + 1'b1;
			end
		end
	end

	//====================
	// count and flags
	//====================
	// flags come straight off ncount so they line up with count
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
			full <= 1'b0;
			empty <= 1'b1;
			fullm1 <= 1'b0;
			emptyp1 <= 1'b0;
		end else begin
			count <= ncount;
			full <= (ncount == (DEPTH_NBITS+1)'(DEPTH));
			empty <= (ncount == '0);
			// one slot left
			fullm1 <= (ncount == (DEPTH_NBITS+1)'(DEPTH - 1));
			// single entry held
			emptyp1 <= (ncount == (DEPTH_NBITS+1)'(1));
		end
	end

endmodule

//--- verilog/sfifo_reg_out.sv
//====================
// sfifo_reg_out
// synchronous fifo with a registered head entry on dout
// storage array sits behind the head stage
//====================

module sfifo_reg_out #(
	parameter int DEPTH_NBITS = 3,
	parameter type payload_t = logic [7:0]
) (
	input logic clk,
	input logic rst_n,
	input logic wr,
	input logic rd,
	input payload_t din,
	output payload_t dout,
	output logic [DEPTH_NBITS:0] count,
	output logic full,
	output logic empty,
	output logic fullm1
);

	localparam int DEPTH = 1 << DEPTH_NBITS;

	logic wr_ok;
	logic rd_ok;
	logic st_wr;
	logic st_rd;
	logic head_ld;
	logic nempty;
	logic st_full;
	logic st_empty;
	logic st_fullm1;
	logic [DEPTH_NBITS:0] st_count;
	logic [DEPTH_NBITS-1:0] rptr;
	logic [DEPTH_NBITS-1:0] wptr;
	payload_t mem [DEPTH];

	// full only when head and storage both hold data
	assign full = st_full & ~empty;
	assign fullm1 = st_fullm1 & ~empty;
	assign count = st_count + {{DEPTH_NBITS{1'b0}}, ~empty};

	assign wr_ok = wr & ~full;
	assign rd_ok = rd & ~empty;

	//====================
	// head stage
	//====================
	// storage is bypassed when the head is free or storage drains on this read
	assign st_wr = wr_ok & ~empty & ~(st_empty & rd_ok);
	assign st_rd = rd_ok & ~st_empty;

	// refill from storage first and fall back to din
	assign head_ld = (wr_ok & empty) | st_rd | (rd_ok & wr_ok);

	// head valid next cycle
	always_comb begin
		if (empty) begin
			nempty = ~wr_ok;
		end else begin
			nempty = rd_ok & st_empty & ~wr_ok;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			empty <= 1'b1;
		end else begin
			empty <= nempty;
		end
	end

	always_ff @(posedge clk) begin
		if (head_ld) begin
			dout <= st_rd ? mem[rptr] : din;
		end
	end

	//====================
	// storage
	//====================
	always_ff @(posedge clk) begin
		if (st_wr) begin
			mem[wptr] <= din;
		end
	end

	sfifo_ctrl #(
		.DEPTH_NBITS (DEPTH_NBITS)
	) u_sfifo_ctrl (
		.clk     (clk),
		.rst_n   (rst_n),
		.rd      (st_rd),
		.wr      (st_wr),
		.count   (st_count),
		.ncount  (),
		.full    (st_full),
		.empty   (st_empty),
		.fullm1  (st_fullm1),
		.emptyp1 (),
		.rptr    (rptr),
		.wptr    (wptr)
	);

endmodule

//--- verilog/irl_meter.sv
//====================
// irl_meter
// per-flow token buckets with green/red marking
// pops metadata and pushes verdicts under back-pressure
//====================

module irl_meter import irl_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic tick,
	input irl_meta_t meta_dout,
	input logic meta_empty,
	input logic verd_full,
	input logic verd_fullm1,
	input logic [TOKEN_NBITS-1:0] rate [NUM_FLOWS],
	input logic [TOKEN_NBITS-1:0] ceil,
	output logic meta_rd,
	output logic verd_wr,
	output irl_verdict_t verd_din,
	output logic [TOKEN_NBITS-1:0] tokens [NUM_FLOWS],
	output logic [15:0] red_count [NUM_FLOWS]
);

	logic accept;
	logic green;
	logic [TOKEN_NBITS-1:0] len_ext;
	logic [TOKEN_NBITS:0] tok_sum [NUM_FLOWS];
	logic [TOKEN_NBITS-1:0] tok_next [NUM_FLOWS];

	//====================
	// pop control
	//====================
	// a verdict still in flight takes the last free slot
	assign accept = ~verd_full & ~(verd_fullm1 & verd_wr);
	assign meta_rd = ~meta_empty & accept;

	// decision on the stored level of the head flow
	assign len_ext = {{(TOKEN_NBITS-LEN_NBITS){1'b0}}, meta_dout.len};
	assign green = (tokens[meta_dout.flow] >= len_ext);

	//====================
	// bucket update
	//====================
	// charge first then refill
	// the extra top bit keeps the refill from wrapping before the clamp
	always_comb begin
		for (int f = 0; f < NUM_FLOWS; f++) begin
			tok_sum[f] = {1'b0, tokens[f]};
			if (meta_rd && green && meta_dout.flow == FLOW_NBITS'(f)) begin
				tok_sum[f] = tok_sum[f] - {1'b0, len_ext};
			end
			if (tick) begin
				tok_sum[f] = tok_sum[f] + {1'b0, rate[f]};
			end
			// clamp to ceiling
			if (tok_sum[f] > {1'b0, ceil}) begin
				tok_next[f] = ceil;
			end else begin
				tok_next[f] = tok_sum[f][TOKEN_NBITS-1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int f = 0; f < NUM_FLOWS; f++) begin
				tokens[f] <= '0;
				red_count[f] <= '0;
			end
			verd_wr <= 1'b0;
		end else begin
			for (int f = 0; f < NUM_FLOWS; f++) begin
				tokens[f] <= tok_next[f];
			end
			// verdict goes out the cycle after the pop
			verd_wr <= meta_rd;
			// red count saturates at all ones
			if (meta_rd && !green && red_count[meta_dout.flow] != 16'hffff) begin
				red_count[meta_dout.flow] <= red_count[meta_dout.flow] + 1'b1;
			end
		end
	end

	//====================
	// verdict register
	//====================
	always_ff @(posedge clk) begin
		if (meta_rd) begin
			verd_din.flow <= meta_dout.flow;
			verd_din.len <= meta_dout.len;
			verd_din.green <= green;
		end
	end

endmodule

//--- verilog/irl_apb_regs.sv
//====================
// irl_apb_regs
// apb slave with rate and ceiling registers
// read-back of meter state and the overflow count
//====================

module irl_apb_regs import irl_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [7:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic meta_ovfl,
	input logic [TOKEN_NBITS-1:0] tokens [NUM_FLOWS],
	input logic [15:0] red_count [NUM_FLOWS],
	output logic [TOKEN_NBITS-1:0] rate [NUM_FLOWS],
	output logic [TOKEN_NBITS-1:0] ceil
);

	logic access;
	logic wr_en;
	logic aligned;
	logic rate_hit;
	logic ceil_hit;
	logic ovfl_hit;
	logic red_hit;
	logic tok_hit;
	logic ro_hit;
	logic mapped;
	logic [FLOW_NBITS-1:0] idx;
	logic [15:0] ovfl_count;

	// no wait states
	assign pready = 1'b1;

	// access phase only
	assign access = psel & penable;
	assign wr_en = access & pwrite;

	//====================
	// address decode
	//====================
	// arrays are four words on a 16 byte boundary
	assign aligned = (paddr[1:0] == 2'b00);
	assign idx = paddr[FLOW_NBITS+1:2];
	assign rate_hit = aligned & (paddr[7:4] == REG_RATE_BASE[7:4]);
	assign ceil_hit = (paddr == REG_CEIL);
	assign ovfl_hit = (paddr == REG_OVFL);
	assign red_hit = aligned & (paddr[7:4] == REG_RED_BASE[7:4]);
	assign tok_hit = aligned & (paddr[7:4] == REG_TOKEN_BASE[7:4]);

	assign ro_hit = ovfl_hit | red_hit | tok_hit;
	assign mapped = rate_hit | ceil_hit | ro_hit;

	// unmapped or a write to read-only space
	assign pslverr = access & (~mapped | (pwrite & ro_hit));

	//====================
	// writable registers
	//====================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int f = 0; f < NUM_FLOWS; f++) begin
				rate[f] <= '0;
			end
			ceil <= '0;
		end else if (wr_en) begin
			if (rate_hit) begin
				rate[idx] <= pwdata[TOKEN_NBITS-1:0];
			end
			if (ceil_hit) begin
				ceil <= pwdata[TOKEN_NBITS-1:0];
			end
		end
	end

	// refused classifier writes, saturating
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ovfl_count <= '0;
		end else if (meta_ovfl && ovfl_count != 16'hffff) begin
			ovfl_count <= ovfl_count + 1'b1;
		end
	end

	// read mux
	always_comb begin
		prdata = '0;
		if (rate_hit) begin
			prdata[TOKEN_NBITS-1:0] = rate[idx];
		end else if (ceil_hit) begin
			prdata[TOKEN_NBITS-1:0] = ceil;
		end else if (ovfl_hit) begin
			prdata[15:0] = ovfl_count;
		end else if (red_hit) begin
			prdata[15:0] = red_count[idx];
		end else if (tok_hit) begin
			prdata[TOKEN_NBITS-1:0] = tokens[idx];
		end
	end

endmodule

//--- verilog/irl_top.sv
//====================
// irl_top
// ingress rate limiter with metadata queue, token meter,
// verdict queue and apb register block
//====================

module irl_top import irl_pkg::*; #(
	parameter int META_DEPTH_NBITS = 3,
	parameter int VERD_DEPTH_NBITS = 2
) (
	input logic clk,
	input logic rst_n,
	input logic tick,
	input logic meta_wr,
	input irl_meta_t meta_din,
	output logic meta_full,
	input logic verdict_rd,
	output irl_verdict_t verdict_dout,
	output logic verdict_empty,
	input logic [7:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);

	irl_meta_t meta_dout;
	logic meta_empty;
	logic meta_rd;
	logic meta_ovfl;
	logic verd_wr;
	logic verd_full;
	logic verd_fullm1;
	irl_verdict_t verd_din;
	logic [TOKEN_NBITS-1:0] rate [NUM_FLOWS];
	logic [TOKEN_NBITS-1:0] ceil;
	logic [TOKEN_NBITS-1:0] tokens [NUM_FLOWS];
	logic [15:0] red_count [NUM_FLOWS];

	// classifier write refused by a full queue
	assign meta_ovfl = meta_wr & meta_full;

	//====================
	// queues
	//====================
	sfifo_reg_out #(
		.DEPTH_NBITS (META_DEPTH_NBITS),
		.payload_t   (irl_meta_t)
	) u_meta_q (
		.clk    (clk),
		.rst_n  (rst_n),
		.wr     (meta_wr),
		.rd     (meta_rd),
		.din    (meta_din),
		.dout   (meta_dout),
		.count  (),
		.full   (meta_full),
		.empty  (meta_empty),
		.fullm1 ()
	);

	sfifo_reg_out #(
		.DEPTH_NBITS (VERD_DEPTH_NBITS),
		.payload_t   (irl_verdict_t)
	) u_verd_q (
		.clk    (clk),
		.rst_n  (rst_n),
		.wr     (verd_wr),
		.rd     (verdict_rd),
		.din    (verd_din),
		.dout   (verdict_dout),
		.count  (),
		.full   (verd_full),
		.empty  (verdict_empty),
		.fullm1 (verd_fullm1)
	);

	//====================
	// meter and registers
	//====================
	irl_meter u_meter (
		.clk         (clk),
		.rst_n       (rst_n),
		.tick        (tick),
		.meta_dout   (meta_dout),
		.meta_empty  (meta_empty),
		.verd_full   (verd_full),
		.verd_fullm1 (verd_fullm1),
		.rate        (rate),
		.ceil        (ceil),
		.meta_rd     (meta_rd),
		.verd_wr     (verd_wr),
		.verd_din    (verd_din),
		.tokens      (tokens),
		.red_count   (red_count)
	);

	irl_apb_regs u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.paddr     (paddr),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.meta_ovfl (meta_ovfl),
		.tokens    (tokens),
		.red_count (red_count),
		.rate      (rate),
		.ceil      (ceil)
	);

endmodule

//--- tests/tb_clk_gen.sv
//====================
// tb_clk_gen
// testbench clock and synchronous reset source
//====================

module tb_clk_gen #(
	parameter int PERIOD = 10,
	parameter int RST_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);

	// free running clock
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// release just after an edge, like the other inputs
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

//--- tests/tb_irl.sv
//====================
// tb_irl
// testbench for the ingress rate limiter
// apb setup, refill, metering, back-pressure and read stalls
// checked against a token bucket reference model
//====================

module tb_irl import irl_pkg::*; ();

	localparam int META_DEPTH_NBITS = 3;
	localparam int VERD_DEPTH_NBITS = 2;
	localparam int RST_CYCLES = 16;
	// both queues plus their head registers
	localparam int TOTAL_CAP = (1 << META_DEPTH_NBITS) + 1 + (1 << VERD_DEPTH_NBITS) + 1;
	localparam int CEIL_VAL = 12000;
	localparam int N_APB = 40;
	localparam int N_TICKS = 10;
	localparam int N_STREAM = 60;
	localparam int N_BURST = 20;
	localparam int N_LONG = 300;
	localparam int WATCHDOG_CYCLES = (N_APB + N_TICKS + N_STREAM + N_BURST + N_LONG) * 20;

	logic clk;
	logic rst_n;
	logic tick;
	logic meta_wr;
	irl_meta_t meta_din;
	logic meta_full;
	logic verdict_rd;
	irl_verdict_t verdict_dout;
	logic verdict_empty;
	logic [7:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	// model state
	logic [31:0] m_tok [NUM_FLOWS];
	logic [15:0] m_red [NUM_FLOWS];
	logic [31:0] m_rate [NUM_FLOWS];
	logic [31:0] m_ceil;
	int m_ovfl;
	irl_verdict_t exp_q [$];
	irl_verdict_t exp_v;

	int errors;
	int test_base;
	int n_tests;
	int n_verdicts;
	logic [31:0] lfsr_state = 32'hf298;

	tb_clk_gen #(
		.PERIOD     (10),
		.RST_CYCLES (RST_CYCLES)
	) u_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	irl_top #(
		.META_DEPTH_NBITS (META_DEPTH_NBITS),
		.VERD_DEPTH_NBITS (VERD_DEPTH_NBITS)
	) DUT (
		.clk           (clk),
		.rst_n         (rst_n),
		.tick          (tick),
		.meta_wr       (meta_wr),
		.meta_din      (meta_din),
		.meta_full     (meta_full),
		.verdict_rd    (verdict_rd),
		.verdict_dout  (verdict_dout),
		.verdict_empty (verdict_empty),
		.paddr         (paddr),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.pwdata        (pwdata),
		.prdata        (prdata),
		.pready        (pready),
		.pslverr       (pslverr)
	);

	//====================
	// helpers
	//====================
	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		errors++;
	endtask

	// galois lfsr, one step per bit
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out) begin
			lfsr_state = lfsr_state ^ 32'h80200003;
		end
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_bit()};
		end
		return r;
	endfunction

	// token rule for one decision, updates the model buckets
	function automatic logic meter_ref(input logic [FLOW_NBITS-1:0] flow,
			input logic [LEN_NBITS-1:0] len);
		logic green;
		green = (m_tok[flow] >= 32'(len));
		if (green) begin
			m_tok[flow] = m_tok[flow] - 32'(len);
		end else if (m_red[flow] != 16'hffff) begin
			m_red[flow] = m_red[flow] + 1'b1;
		end
		return green;
	endfunction

	//====================
	// apb access
	//====================
	// setup phase, then access phase sampled at the falling edge
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		rdata = prdata;
		err = pslverr;
		if (pready !== 1'b1) begin
			report_mismatch("pready", pready, 1'b1);
		end
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic err;
		apb_xfer(1'b1, addr, data, rdata, err);
		if (err !== 1'b0) begin
			report_mismatch("pslverr", err, 1'b0);
		end
	endtask

	task automatic apb_read_check(input logic [7:0] addr, input logic [31:0] exp,
			input string label);
		logic [31:0] rdata;
		logic err;
		apb_xfer(1'b0, addr, '0, rdata, err);
		if (rdata !== exp) begin
			report_mismatch($sformatf("prdata %s @0x%02h", label, addr), rdata, exp);
		end
		if (err !== 1'b0) begin
			report_mismatch("pslverr", err, 1'b0);
		end
	endtask

	task automatic apb_expect_err(input logic wr, input logic [7:0] addr);
		logic [31:0] rdata;
		logic err;
		apb_xfer(wr, addr, 32'h5, rdata, err);
		if (err !== 1'b1) begin
			report_mismatch($sformatf("pslverr @0x%02h", addr), err, 1'b1);
		end
	endtask

	//====================
	// stimulus
	//====================
	// one tick per cycle, queues are empty here
	task automatic tick_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			#1;
			tick = 1'b1;
			for (int f = 0; f < NUM_FLOWS; f++) begin
				if (m_tok[f] + m_rate[f] > m_ceil) begin
					m_tok[f] = m_ceil;
				end else begin
					m_tok[f] = m_tok[f] + m_rate[f];
				end
			end
		end
		@(posedge clk);
		#1;
		tick = 1'b0;
	endtask

	// classifier honours meta_full, reader always on or random
	task automatic run_stream(input int npkt, input logic stall, input int len_bits);
		irl_meta_t m;
		irl_verdict_t v;
		int sent;
		sent = 0;
		while (sent < npkt || exp_q.size() != 0) begin
			@(posedge clk);
			#1;
			verdict_rd = stall ? lfsr_bit() : 1'b1;
			meta_wr = 1'b0;
			if (sent < npkt && !meta_full) begin
				m.flow = FLOW_NBITS'(rand_bits(FLOW_NBITS));
				m.len = LEN_NBITS'(rand_bits(len_bits));
				v.flow = m.flow;
				v.len = m.len;
				v.green = meter_ref(m.flow, m.len);
				exp_q.push_back(v);
				meta_din = m;
				meta_wr = 1'b1;
				sent++;
			end
		end
		@(posedge clk);
		#1;
		meta_wr = 1'b0;
		verdict_rd = 1'b0;
		@(negedge clk);
		// nothing left over and nothing read twice
		if (verdict_empty !== 1'b1) begin
			report_mismatch("verdict_empty", verdict_empty, 1'b1);
		end
	endtask

	task automatic check_counters();
		for (int f = 0; f < NUM_FLOWS; f++) begin
			apb_read_check(REG_TOKEN_BASE + 8'(4 * f), m_tok[f], "tokens");
			apb_read_check(REG_RED_BASE + 8'(4 * f), 32'(m_red[f]), "red_count");
		end
		apb_read_check(REG_OVFL, 32'(m_ovfl), "ovfl");
	endtask

	// writes with reads held off, the excess must be refused
	task automatic burst_test();
		irl_meta_t m;
		irl_verdict_t v;
		int accepted;
		accepted = 0;
		for (int i = 0; i < N_BURST; i++) begin
			@(posedge clk);
			#1;
			m.flow = FLOW_NBITS'(rand_bits(FLOW_NBITS));
			m.len = LEN_NBITS'(rand_bits(11));
			meta_din = m;
			meta_wr = 1'b1;
			if (accepted < TOTAL_CAP) begin
				v.flow = m.flow;
				v.len = m.len;
				v.green = meter_ref(m.flow, m.len);
				exp_q.push_back(v);
				accepted++;
			end else begin
				m_ovfl++;
			end
		end
		@(posedge clk);
		#1;
		meta_wr = 1'b0;
		@(negedge clk);
		if (meta_full !== 1'b1) begin
			report_mismatch("meta_full", meta_full, 1'b1);
		end
		apb_read_check(REG_OVFL, 32'(m_ovfl), "ovfl");
		run_stream(0, 1'b0, 0);
		if (meta_full !== 1'b0) begin
			report_mismatch("meta_full", meta_full, 1'b0);
		end
		check_counters();
	endtask

	task automatic end_test(input string name);
		$display("test %s: %0d errors", name, errors - test_base);
		test_base = errors;
		n_tests++;
	endtask

	//====================
	// verdict compare
	//====================
	// head is valid at the falling edge and pops at the next rising edge
	always @(negedge clk) begin
		if (rst_n && verdict_rd && !verdict_empty) begin
			if (exp_q.size() == 0) begin
				$display("unexpected verdict from the DUT: 0x%0h", verdict_dout);
				errors++;
			end else begin
				exp_v = exp_q.pop_front();
				n_verdicts++;
				if (verdict_dout.flow !== exp_v.flow) begin
					report_mismatch("verdict_dout.flow", verdict_dout.flow, exp_v.flow);
				end
				if (verdict_dout.len !== exp_v.len) begin
					report_mismatch("verdict_dout.len", verdict_dout.len, exp_v.len);
				end
				if (verdict_dout.green !== exp_v.green) begin
					report_mismatch("verdict_dout.green", verdict_dout.green, exp_v.green);
				end
			end
		end
	end

	// watchdog
	initial begin
		repeat (RST_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

	//====================
	// main sequence
	//====================
	initial begin
		tick = 1'b0;
		meta_wr = 1'b0;
		meta_din = '0;
		verdict_rd = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		errors = 0;
		test_base = 0;
		n_tests = 0;
		n_verdicts = 0;
		m_ovfl = 0;
		m_ceil = '0;
		for (int f = 0; f < NUM_FLOWS; f++) begin
			m_tok[f] = '0;
			m_red[f] = '0;
			m_rate[f] = '0;
		end
		wait (rst_n === 1'b1);
		@(negedge clk);

		// reset state, register access, bus errors
		if (verdict_empty !== 1'b1) begin
			report_mismatch("verdict_empty", verdict_empty, 1'b1);
		end
		if (meta_full !== 1'b0) begin
			report_mismatch("meta_full", meta_full, 1'b0);
		end
		check_counters();
		// rates grow with the flow number
		for (int f = 0; f < NUM_FLOWS; f++) begin
			m_rate[f] = 32'(100 * (f + 1) * (f + 1));
			apb_write(REG_RATE_BASE + 8'(4 * f), m_rate[f]);
		end
		m_ceil = 32'(CEIL_VAL);
		apb_write(REG_CEIL, m_ceil);
		for (int f = 0; f < NUM_FLOWS; f++) begin
			apb_read_check(REG_RATE_BASE + 8'(4 * f), m_rate[f], "rate");
		end
		apb_read_check(REG_CEIL, m_ceil, "ceil");
		apb_expect_err(1'b0, 8'h18);
		apb_expect_err(1'b1, 8'h80);
		apb_expect_err(1'b1, REG_TOKEN_BASE);
		apb_read_check(REG_TOKEN_BASE, '0, "tokens");
		end_test("1 reset and registers");

		// refill only, min of n times rate and ceiling
		tick_cycles(N_TICKS);
		for (int f = 0; f < NUM_FLOWS; f++) begin
			apb_read_check(REG_TOKEN_BASE + 8'(4 * f),
				(N_TICKS * m_rate[f] > m_ceil) ? m_ceil : N_TICKS * m_rate[f], "tokens");
		end
		end_test("2 refill");

		run_stream(N_STREAM, 1'b0, 11);
		check_counters();
		end_test("3 metering");

		burst_test();
		end_test("4 back-pressure");

		tick_cycles(3);
		run_stream(N_LONG, 1'b1, 9);
		check_counters();
		end_test("5 read stalls");

		$display("tests: %0d, verdicts compared: %0d, errors: %0d", n_tests, n_verdicts,
			errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- list.f
verilog/irl_pkg.sv
verilog/sfifo_ctrl.sv
verilog/sfifo_reg_out.sv
verilog/irl_meter.sv
verilog/irl_apb_regs.sv
verilog/irl_top.sv
tests/tb_clk_gen.sv
tests/tb_irl.sv
